// ==== common/CpuPkg.sv ====
`default_nettype none

package CpuPkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int REG_AW     = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } Opcode;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } AluOp;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } BranchKind;

endpackage

`default_nettype wire

// ==== common/PipeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface PipeIf
    import CpuPkg::*;
();

    logic              valid;
    logic [XLEN-1:0]   pc;
    AluOp              aluOp;
    BranchKind         branchKind;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              rs1Use;
    logic              rs2Use;
    logic [XLEN-1:0]   rdata1;
    logic [XLEN-1:0]   rdata2;
    logic [XLEN-1:0]   imm;
    logic              useImm;
    logic              regWrite;
    logic              memRead;
    logic              memWrite;

    modport source (
        output valid, pc, aluOp, branchKind, rs1, rs2, rd, rs1Use, rs2Use,
               rdata1, rdata2, imm, useImm, regWrite, memRead, memWrite
    );

    modport sink (
        input valid, pc, aluOp, branchKind, rs1, rs2, rd, rs1Use, rs2Use,
              rdata1, rdata2, imm, useImm, regWrite, memRead, memWrite
    );

endinterface

`default_nettype wire

// ==== decode/Decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module Decoder
    import CpuPkg::*;
(
    input  logic [XLEN-1:0] inst,
    output AluOp            aluOp,
    output BranchKind       branchKind,
    output logic [XLEN-1:0] imm,
    output logic            useImm,
    output logic            rs1Use,
    output logic            rs2Use,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite
);

    Opcode           opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;

    assign opcode = Opcode'(inst[6:0]);
    assign funct3 = inst[14:12];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        aluOp      = ALU_ADD;
        branchKind = BR_NONE;
        imm        = immI;
        useImm     = 1'b0;
        rs1Use     = 1'b0;
        rs2Use     = 1'b0;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        case (opcode)
            OP_REG: begin
                rs1Use   = 1'b1;
                rs2Use   = 1'b1;
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  aluOp = ALU_SLT;
                    3'b100:  aluOp = ALU_XOR;
                    3'b110:  aluOp = ALU_OR;
                    3'b111:  aluOp = ALU_AND;
                    default: regWrite = 1'b0;
                endcase
            end
            OP_IMM: begin
                rs1Use   = 1'b1;
                useImm   = 1'b1;
                regWrite = (funct3 == 3'b000);
            end
            OP_LOAD: begin
                rs1Use   = 1'b1;
                useImm   = 1'b1;
                regWrite = (funct3 == 3'b010);
                memRead  = (funct3 == 3'b010);
            end
            OP_STORE: begin
                rs1Use   = 1'b1;
                rs2Use   = 1'b1;
                useImm   = 1'b1;
                imm      = immS;
                memWrite = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                rs1Use = 1'b1;
                rs2Use = 1'b1;
                imm    = immB;
                case (funct3)
                    3'b000:  branchKind = BR_EQ;
                    3'b001:  branchKind = BR_NE;
                    default: branchKind = BR_NONE;
                endcase
            end
            OP_JAL: begin
                imm        = immJ;
                regWrite   = 1'b1;
                branchKind = BR_JAL;
            end
            default: begin
                // Unknown opcode behaves as a NOP
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/RegFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module RegFile
    import CpuPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    logic [XLEN-1:0] regs [2**REG_AW];

    // Same-cycle writeback is visible to decode
    function automatic logic [XLEN-1:0] readPort(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = readPort(raddr1);
        rdata2 = readPort(raddr2);
    end

endmodule

`default_nettype wire

// ==== decode/DecodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module DecodeStage
    import CpuPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [XLEN-1:0]   idPc,
    input  logic [XLEN-1:0]   idInst,
    input  logic              stall,
    input  logic              flush,
    input  logic [REG_AW-1:0] wbRd,
    input  logic              wbRegWrite,
    input  logic [XLEN-1:0]   wbData,
    output logic [REG_AW-1:0] idRs1,
    output logic [REG_AW-1:0] idRs2,
    output logic              idRs1Use,
    output logic              idRs2Use,
    PipeIf.source             exBus
);

    AluOp            aluOp;
    BranchKind       branchKind;
    logic [XLEN-1:0] imm;
    logic            useImm;
    logic            regWrite;
    logic            memRead;
    logic            memWrite;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic            bubble;

    assign idRs1 = idInst[19:15];
    assign idRs2 = idInst[24:20];

    // The NOP that fetch puts in IF/ID marks an empty slot
    assign bubble = stall || flush || (idInst == NOP_INST);

    Decoder decoder (
        .inst       (idInst),
        .aluOp      (aluOp),
        .branchKind (branchKind),
        .imm        (imm),
        .useImm     (useImm),
        .rs1Use     (idRs1Use),
        .rs2Use     (idRs2Use),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite)
    );

    RegFile regFile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (idRs1),
        .raddr2 (idRs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (wbRegWrite),
        .waddr  (wbRd),
        .wdata  (wbData)
    );

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            exBus.valid      <= 1'b0;
            exBus.branchKind <= BR_NONE;
            exBus.regWrite   <= 1'b0;
            exBus.memRead    <= 1'b0;
            exBus.memWrite   <= 1'b0;
        end else begin
            exBus.valid      <= 1'b1;
            exBus.branchKind <= branchKind;
            exBus.regWrite   <= regWrite;
            exBus.memRead    <= memRead;
            exBus.memWrite   <= memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exBus.pc     <= idPc;
        exBus.aluOp  <= aluOp;
        exBus.rs1    <= idRs1;
        exBus.rs2    <= idRs2;
        exBus.rd     <= idInst[11:7];
        exBus.rs1Use <= idRs1Use;
        exBus.rs2Use <= idRs2Use;
        exBus.rdata1 <= rdata1;
        exBus.rdata2 <= rdata2;
        exBus.imm    <= imm;
        exBus.useImm <= useImm;
    end

endmodule

`default_nettype wire

// ==== rtl/Fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module Fetch
    import CpuPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               progWrite,
    input  logic [IMEM_AW-1:0] progAddr,
    input  logic [XLEN-1:0]    progData,
    input  logic               stall,
    input  logic               redirect,
    input  logic [XLEN-1:0]    redirectPc,
    output logic [XLEN-1:0]    idPc,
    output logic [XLEN-1:0]    idInst
);

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] fetchInst;

    assign fetchInst = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

    // Redirect wins over stall and kills the word being fetched
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            idInst <= NOP_INST;
        end else if (redirect) begin
            pc     <= redirectPc;
            idInst <= NOP_INST;
        end else if (!stall) begin
            pc     <= pc + XLEN'(4);
            idInst <= fetchInst;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idPc <= pc;
        end
    end

    // Program loading only while the core is held in reset
    assert property (@(posedge clk) progWrite |-> reset)
        else $error("imem write outside reset");

endmodule

`default_nettype wire

// ==== rtl/Execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module Execute
    import CpuPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    PipeIf.sink               exBus,
    input  logic [REG_AW-1:0] wbRd,
    input  logic              wbRegWrite,
    input  logic [XLEN-1:0]   wbData,
    output logic              exMemRead,
    output logic [REG_AW-1:0] exRd,
    output logic              redirect,
    output logic [XLEN-1:0]   redirectPc,
    output logic              memValid,
    output logic [XLEN-1:0]   memPc,
    output logic [REG_AW-1:0] memRd,
    output logic              memRegWrite,
    output logic              memRead,
    output logic              memWrite,
    output logic [XLEN-1:0]   memAluRes,
    output logic [XLEN-1:0]   memStoreData
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] result;
    logic            taken;

    function automatic logic [XLEN-1:0] forward(
        input logic [REG_AW-1:0] src,
        input logic              srcUse,
        input logic [XLEN-1:0]   regVal
    );
        if (srcUse && src != '0) begin
            // Load data in MEM arrives too late to forward
            if (memRegWrite && !memRead && memRd == src) begin
                return memAluRes;
            end
            if (wbRegWrite && wbRd == src) begin
                return wbData;
            end
        end
        return regVal;
    endfunction

    always_comb begin
        opA  = forward(exBus.rs1, exBus.rs1Use, exBus.rdata1);
        srcB = forward(exBus.rs2, exBus.rs2Use, exBus.rdata2);
    end

    assign opB = exBus.useImm ? exBus.imm : srcB;

    always_comb begin
        case (exBus.aluOp)
            ALU_SUB: aluRes = opA - opB;
            ALU_AND: aluRes = opA & opB;
            ALU_OR:  aluRes = opA | opB;
            ALU_XOR: aluRes = opA ^ opB;
            ALU_SLT: aluRes = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluRes = opA + opB;
        endcase
    end

    always_comb begin
        case (exBus.branchKind)
            BR_EQ:   taken = (opA == srcB);
            BR_NE:   taken = (opA != srcB);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = exBus.valid && taken;
    assign redirectPc = exBus.pc + exBus.imm;
    assign exMemRead  = exBus.memRead;
    assign exRd       = exBus.rd;

    // JAL writes the link address
    assign result = (exBus.branchKind == BR_JAL) ? exBus.pc + XLEN'(4) : aluRes;

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
        end else begin
            memValid    <= exBus.valid;
            memRegWrite <= exBus.regWrite;
            memRead     <= exBus.memRead;
            memWrite    <= exBus.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        memPc        <= exBus.pc;
        memRd        <= exBus.rd;
        memAluRes    <= result;
        memStoreData <= srcB;
    end

    assert property (@(posedge clk) disable iff (reset) redirect |-> redirectPc[1:0] == 2'b00)
        else $error("misaligned redirect target %h", redirectPc);

endmodule

`default_nettype wire

// ==== rtl/MemWriteback.sv ====
`timescale 1ns/10ps
`default_nettype none

module MemWriteback
    import CpuPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              memValid,
    input  logic [XLEN-1:0]   memPc,
    input  logic [REG_AW-1:0] memRd,
    input  logic              memRegWrite,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic [XLEN-1:0]   memAluRes,
    input  logic [XLEN-1:0]   memStoreData,
    output logic [REG_AW-1:0] wbRd,
    output logic              wbRegWrite,
    output logic [XLEN-1:0]   wbData,
    output logic              retireValid,
    output logic [XLEN-1:0]   retirePc,
    output logic [REG_AW-1:0] retireRd,
    output logic [XLEN-1:0]   retireData
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmemIdx;
    logic [XLEN-1:0]    loadData;

    assign dmemIdx  = memAluRes[DMEM_AW+1:2];
    assign loadData = dmem[dmemIdx];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[dmemIdx] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
            wbRegWrite  <= 1'b0;
        end else begin
            retireValid <= memValid;
            wbRegWrite  <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        retirePc <= memPc;
        wbRd     <= memRd;
        wbData   <= memRead ? loadData : memAluRes;
    end

    assign retireRd   = wbRegWrite ? wbRd : '0;
    assign retireData = wbData;

endmodule

`default_nettype wire

// ==== rtl/HazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module HazardUnit
    import CpuPkg::*;
(
    input  logic [REG_AW-1:0] idRs1,
    input  logic [REG_AW-1:0] idRs2,
    input  logic              idRs1Use,
    input  logic              idRs2Use,
    input  logic              exMemRead,
    input  logic [REG_AW-1:0] exRd,
    input  logic              redirect,
    output logic              stall,
    output logic              flush
);

    logic rs1Hit;
    logic rs2Hit;

    assign rs1Hit = idRs1Use && (idRs1 == exRd);
    assign rs2Hit = idRs2Use && (idRs2 == exRd);

    // Load-use costs one bubble, unless the load's slot is being redirected past
    assign stall = exMemRead && (exRd != '0) && (rs1Hit || rs2Hit) && !redirect;
    assign flush = redirect || stall;

endmodule

`default_nettype wire

// ==== rtl/MiniCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module MiniCpu
    import CpuPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               progWrite,
    input  logic [IMEM_AW-1:0] progAddr,
    input  logic [XLEN-1:0]    progData,
    output logic               retireValid,
    output logic [XLEN-1:0]    retirePc,
    output logic [REG_AW-1:0]  retireRd,
    output logic [XLEN-1:0]    retireData
);

    logic [XLEN-1:0]   idPc;
    logic [XLEN-1:0]   idInst;
    logic [REG_AW-1:0] idRs1;
    logic [REG_AW-1:0] idRs2;
    logic              idRs1Use;
    logic              idRs2Use;
    logic              stall;
    logic              flush;
    logic              exMemRead;
    logic [REG_AW-1:0] exRd;
    logic              redirect;
    logic [XLEN-1:0]   redirectPc;
    logic              memValid;
    logic [XLEN-1:0]   memPc;
    logic [REG_AW-1:0] memRd;
    logic              memRegWrite;
    logic              memRead;
    logic              memWrite;
    logic [XLEN-1:0]   memAluRes;
    logic [XLEN-1:0]   memStoreData;
    logic [REG_AW-1:0] wbRd;
    logic              wbRegWrite;
    logic [XLEN-1:0]   wbData;

    PipeIf exBus ();

    Fetch fetch (
        .clk        (clk),
        .reset      (reset),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .idPc       (idPc),
        .idInst     (idInst)
    );

    DecodeStage decode (
        .clk        (clk),
        .reset      (reset),
        .idPc       (idPc),
        .idInst     (idInst),
        .stall      (stall),
        .flush      (flush),
        .wbRd       (wbRd),
        .wbRegWrite (wbRegWrite),
        .wbData     (wbData),
        .idRs1      (idRs1),
        .idRs2      (idRs2),
        .idRs1Use   (idRs1Use),
        .idRs2Use   (idRs2Use),
        .exBus      (exBus.source)
    );

    Execute execute (
        .clk          (clk),
        .reset        (reset),
        .exBus        (exBus.sink),
        .wbRd         (wbRd),
        .wbRegWrite   (wbRegWrite),
        .wbData       (wbData),
        .exMemRead    (exMemRead),
        .exRd         (exRd),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .memValid     (memValid),
        .memPc        (memPc),
        .memRd        (memRd),
        .memRegWrite  (memRegWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAluRes    (memAluRes),
        .memStoreData (memStoreData)
    );

    MemWriteback memWb (
        .clk          (clk),
        .reset        (reset),
        .memValid     (memValid),
        .memPc        (memPc),
        .memRd        (memRd),
        .memRegWrite  (memRegWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memAluRes    (memAluRes),
        .memStoreData (memStoreData),
        .wbRd         (wbRd),
        .wbRegWrite   (wbRegWrite),
        .wbData       (wbData),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRd     (retireRd),
        .retireData   (retireData)
    );

    HazardUnit hazard (
        .idRs1     (idRs1),
        .idRs2     (idRs2),
        .idRs1Use  (idRs1Use),
        .idRs2Use  (idRs2Use),
        .exMemRead (exMemRead),
        .exRd      (exRd),
        .redirect  (redirect),
        .stall     (stall),
        .flush     (flush)
    );

endmodule

`default_nettype wire

// ==== sim/CpuTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module CpuTb
    import CpuPkg::*;
();

    localparam int NUM_TESTS     = 5;
    localparam int TOTAL_RETIRES = 7 + 6 + 8 + 4 + 31;
    localparam int CYCLE_LIMIT   = TOTAL_RETIRES * 8 + 60 * NUM_TESTS;

    logic               clk;
    logic               reset;
    logic               progWrite;
    logic [IMEM_AW-1:0] progAddr;
    logic [XLEN-1:0]    progData;
    logic               retireValid;
    logic [XLEN-1:0]    retirePc;
    logic [REG_AW-1:0]  retireRd;
    logic [XLEN-1:0]    retireData;

    logic [31:0]        prog [$];
    logic [31:0]        expPc [$];
    logic [REG_AW-1:0]  expRd [$];
    logic [31:0]        expData [$];
    logic [31:0]        model [32];
    logic [31:0]        lcgState;
    int                 passCount;
    int                 failCount;
    int                 runCycles = 0;

    MiniCpu dut_i (
        .clk         (clk),
        .reset       (reset),
        .progWrite   (progWrite),
        .progAddr    (progAddr),
        .progData    (progData),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    always #4 clk = ~clk;

    // Only cycles with the core out of reset count toward the limit
    always @(posedge clk) begin
        if (!reset) begin
            runCycles++;
        end
        if (runCycles > CYCLE_LIMIT) begin
            $display("Error: timeout waiting for retire after %0d cycles", runCycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeI(input int imm, input int rs1, input logic [2:0] f3,
                                            input int rd, input logic [6:0] op);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return encodeI(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return encodeI(imm, rs1, 3'b010, rd, 7'b0000011);
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
    endfunction

    // Branch offset is relative to the branch itself
    function automatic logic [31:0] encodeB(input logic [2:0] f3, input int rs1, input int rs2,
                                            input int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] lessThan(input logic [31:0] a, input logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic int nextPc();
        return prog.size() * 4;
    endfunction

    task automatic startProgram();
        prog.delete();
        expPc.delete();
        expRd.delete();
        expData.delete();
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
    endtask

    // Instruction that must retire, with the register it writes
    task automatic emitRetired(input logic [31:0] word, input int rd, input logic [31:0] value);
        expPc.push_back(32'(nextPc()));
        expRd.push_back(REG_AW'(rd));
        expData.push_back(value);
        prog.push_back(word);
        if (rd != 0) begin
            model[rd] = value;
        end
    endtask

    task automatic emitSkipped(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic runProgram(input string name);
        int errs;
        int seen;
        errs = 0;
        seen = 0;
        reset = 1'b1;
        repeat (16) @(negedge clk);
        // Rest of memory spins on JAL x0, 0
        for (int a = 0; a < IMEM_WORDS; a++) begin
            progWrite = 1'b1;
            progAddr  = IMEM_AW'(a);
            progData  = (a < prog.size()) ? prog[a] : jal(0, 0);
            @(negedge clk);
        end
        progWrite = 1'b0;
        reset     = 1'b0;
        while (seen < expPc.size()) begin
            @(negedge clk);
            if (retireValid) begin
                assert (retirePc == expPc[seen]) else begin
                    $display("Mismatch at %0t: retirePc got %h expected %h",
                             $time, retirePc, expPc[seen]);
                    errs++;
                end
                assert (retireRd == expRd[seen]) else begin
                    $display("Mismatch at %0t: retireRd got %0d expected %0d",
                             $time, retireRd, expRd[seen]);
                    errs++;
                end
                if (expRd[seen] != '0) begin
                    assert (retireData == expData[seen]) else begin
                        $display("Mismatch at %0t: retireData got %h expected %h",
                                 $time, retireData, expData[seen]);
                        errs++;
                    end
                end
                seen++;
            end
        end
        if (errs == 0) begin
            passCount++;
            $display("Test %s: ok, %0d retires", name, seen);
        end else begin
            failCount++;
            $display("Test %s: %0d errors", name, errs);
        end
    endtask

    task automatic testAluChain();
        startProgram();
        emitRetired(addi(1, 0, 25), 1, 32'd25);
        emitRetired(encodeR(7'h00, 3'b000, 2, 1, 1), 2, model[1] + model[1]);
        emitRetired(encodeR(7'h20, 3'b000, 3, 1, 2), 3, model[1] - model[2]);
        emitRetired(encodeR(7'h00, 3'b111, 4, 3, 2), 4, model[3] & model[2]);
        emitRetired(encodeR(7'h00, 3'b110, 5, 4, 1), 5, model[4] | model[1]);
        emitRetired(encodeR(7'h00, 3'b100, 6, 5, 3), 6, model[5] ^ model[3]);
        // Negative against positive, where signed and unsigned compares differ
        emitRetired(encodeR(7'h00, 3'b010, 7, 6, 1), 7, lessThan(model[6], model[1]));
        runProgram("alu chain");
    endtask

    task automatic testStoreLoad();
        startProgram();
        emitRetired(addi(1, 0, 64), 1, 32'd64);
        emitRetired(addi(2, 0, -123), 2, -32'sd123);
        emitRetired(sw(2, 1, 8), 0, '0);
        emitRetired(lw(3, 1, 8), 3, model[2]);
        // Uses the loaded register right away
        emitRetired(encodeR(7'h00, 3'b000, 4, 3, 1), 4, model[3] + model[1]);
        emitRetired(addi(5, 4, 1), 5, model[4] + 32'd1);
        runProgram("store load");
    endtask

    task automatic testBranches();
        startProgram();
        emitRetired(addi(1, 0, 5), 1, 32'd5);
        emitRetired(addi(2, 0, 5), 2, 32'd5);
        emitRetired(encodeB(3'b000, 1, 2, 12), 0, '0);
        emitSkipped(addi(3, 0, 1));
        emitSkipped(addi(3, 0, 2));
        emitRetired(addi(4, 0, 7), 4, 32'd7);
        emitRetired(encodeB(3'b001, 1, 4, 12), 0, '0);
        emitSkipped(addi(3, 0, 3));
        emitSkipped(addi(3, 0, 4));
        emitRetired(encodeB(3'b000, 1, 4, 12), 0, '0);
        emitRetired(encodeB(3'b001, 1, 2, 12), 0, '0);
        // x3 stays zero unless a flushed instruction wrote it
        emitRetired(addi(5, 3, 9), 5, model[3] + 32'd9);
        runProgram("branches");
    endtask

    task automatic testJal();
        logic [31:0] link;
        startProgram();
        emitRetired(addi(1, 0, 11), 1, 32'd11);
        link = 32'(nextPc() + 4);
        emitRetired(jal(5, 16), 5, link);
        emitSkipped(addi(1, 0, 99));
        emitSkipped(addi(1, 0, 98));
        emitSkipped(addi(1, 0, 97));
        emitRetired(encodeR(7'h00, 3'b000, 6, 5, 1), 6, model[5] + model[1]);
        emitRetired(addi(7, 6, 1), 7, model[6] + 32'd1);
        runProgram("jal");
    endtask

    task automatic testRandomAddi();
        logic [31:0] rnd;
        logic [31:0] immVal;
        startProgram();
        for (int i = 0; i < 20; i++) begin
            rnd    = nextRandom();
            immVal = {{20{rnd[27]}}, rnd[27:16]};
            emitRetired(addi(8, 8, immVal), 8, model[8] + immVal);
            if (i % 2 == 1) begin
                rnd = nextRandom();
                emitRetired(addi(0, 8, {{20{rnd[27]}}, rnd[27:16]}), 0, '0);
            end
        end
        emitRetired(encodeR(7'h00, 3'b000, 9, 0, 8), 9, model[8]);
        runProgram("random addi chain");
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lcgState  = 32'd89191;
        passCount = 0;
        failCount = 0;
        testAluChain();
        testStoreLoad();
        testBranches();
        testJal();
        testRandomAddi();
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/CpuPkg.sv
common/PipeIf.sv
decode/Decoder.sv
decode/RegFile.sv
decode/DecodeStage.sv
rtl/Fetch.sv
rtl/Execute.sv
rtl/MemWriteback.sv
rtl/HazardUnit.sv
rtl/MiniCpu.sv
sim/CpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CpuTb simulation with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module CpuTb -f verilog.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
